// ==== files.f ====
color_proc_pkg.sv
frame_scanner.sv
filter_select.sv
color_classifier.sv
color_histogram.sv
color_proc.sv
tb_color_proc.sv

// ==== Bender.yml ====
package:
  name: color_proc

sources:
  - color_proc_pkg.sv
  - frame_scanner.sv
  - filter_select.sv
  - color_classifier.sv
  - color_histogram.sv
  - color_proc.sv
  - target: test
    files:
      - tb_color_proc.sv

// ==== tb_color_proc.sv ====
// directed testbench for color_proc with models of both frame memories and of the color rule
`timescale 1ns/1ns

module tb_color_proc;

  logic                                       clk, rst, new_frame, proc_ctrl;
  color_proc_pkg::pxl_t                       orig_pxl, proc_pxl;
  color_proc_pkg::pxl_addr_t                  orig_addr, proc_addr;
  logic                                       proc_we, frame_done;
  color_proc_pkg::hist_bins_t                 histogram;
  logic [color_proc_pkg::nb_inframe_pxls-1:0] colorpxls;
  color_proc_pkg::rgb_filter_e                rgbfilter;

  color_proc_pkg::pxl_t src_mem [color_proc_pkg::img_pxls];  // source frame buffer
  color_proc_pkg::pxl_t cap_mem [color_proc_pkg::img_pxls];  // processed image as written
  int wr_cnt, done_cnt, err_cnt, test_cnt, fail_cnt;
  int exp_bins [8];  // model counts per bin
  int exp_tot;

  // button sequence starting from none
  color_proc_pkg::rgb_filter_e step_order [8] = '{
    color_proc_pkg::filt_none, color_proc_pkg::filt_red, color_proc_pkg::filt_green,
    color_proc_pkg::filt_blue, color_proc_pkg::filt_yellow, color_proc_pkg::filt_magenta,
    color_proc_pkg::filt_cyan, color_proc_pkg::filt_white};

  color_proc i_dut (
    .clk(clk), .rst(rst), .new_frame_i(new_frame), .proc_ctrl_i(proc_ctrl),
    .orig_pxl_i(orig_pxl), .orig_addr_o(orig_addr), .proc_we_o(proc_we),
    .proc_addr_o(proc_addr), .proc_pxl_o(proc_pxl), .new_frame_proc_o(frame_done),
    .histogram_o(histogram), .colorpxls_o(colorpxls), .rgbfilter_o(rgbfilter)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  always @(posedge clk) orig_pxl <= src_mem[orig_addr];  // synchronous read with one cycle latency

  // result memory and strobe counters sampled mid cycle
  always @(negedge clk) begin
    if (proc_we) begin
      cap_mem[proc_addr] = proc_pxl;
      wr_cnt++;
    end
    if (frame_done) done_cnt++;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got %0h, expected %0h", name, got, want);
      err_cnt++;
    end
  endtask

  function automatic bit near(input int a, input int b);
    return (a - b <= 2) && (b - a <= 2);
  endfunction

  // a primary wins when its channel tops both others by 7 or more
  // a mix needs two near channels that both sit 7 above the third
  // white is a bright gray with all channels close together
  function automatic bit passes(input color_proc_pkg::pxl_t pxl,
                                input color_proc_pkg::rgb_filter_e filt);
    int r, g, b, hi, lo;
    r  = pxl[11:8];
    g  = pxl[7:4];
    b  = pxl[3:0];
    hi = (r > g) ? r : g;
    hi = (hi > b) ? hi : b;
    lo = (r < g) ? r : g;
    lo = (lo < b) ? lo : b;
    case (filt)
      color_proc_pkg::filt_red:     return (r - g >= 7) && (r - b >= 7);
      color_proc_pkg::filt_green:   return (g - r >= 7) && (g - b >= 7);
      color_proc_pkg::filt_blue:    return (b - r >= 7) && (b - g >= 7);
      color_proc_pkg::filt_yellow:  return near(r, g) && (r - b >= 7) && (g - b >= 7);
      color_proc_pkg::filt_magenta: return near(r, b) && (r - g >= 7) && (b - g >= 7);
      color_proc_pkg::filt_cyan:    return near(g, b) && (g - r >= 7) && (b - r >= 7);
      color_proc_pkg::filt_white:   return (hi - lo <= 2) && (lo >= 12);
      default:                      return 1'b1;  // none keeps all
    endcase
  endfunction

  // filter that one button press should select
  function automatic color_proc_pkg::rgb_filter_e next_filter(
    input color_proc_pkg::rgb_filter_e cur);
    int i;
    for (i = 0; i < 8; i++)
      if (step_order[i] == cur) return step_order[(i + 1) % 8];
    return color_proc_pkg::filt_none;
  endfunction

  // strobes a frame and waits for done
  // a second strobe after restart_at cycles lands mid scan
  task automatic run_frame(input int restart_at);
    int n;
    wr_cnt   = 0;
    done_cnt = 0;
    @(posedge clk);
    new_frame <= 1'b1;
    @(posedge clk);
    new_frame <= 1'b0;
    if (restart_at > 0) begin
      repeat (restart_at) @(posedge clk);
      new_frame <= 1'b1;  // should be ignored
      @(posedge clk);
      new_frame <= 1'b0;
    end
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!frame_done && n < 20000);
    if (!frame_done) begin
      $display("timeout: no frame done pulse within 20000 cycles");
      err_cnt++;
    end
    repeat (4) @(posedge clk);
    check("proc_we_o count", wr_cnt, color_proc_pkg::img_pxls);
    check("new_frame_proc_o count", done_cnt, 1);
  endtask

  // compare captured image and counts against the model for the current source
  task automatic verify_frame(input color_proc_pkg::rgb_filter_e filt);
    int a, i, col, row, e0;
    bit ok;
    color_proc_pkg::pxl_t want;
    e0      = err_cnt;
    exp_tot = 0;
    for (i = 0; i < 8; i++) exp_bins[i] = 0;
    for (a = 0; a < color_proc_pkg::img_pxls; a++) begin
      col  = a % 160;
      row  = a / 160;
      ok   = passes(src_mem[a], filt);
      want = ok ? src_mem[a] : 12'h000;
      if (err_cnt == e0) check($sformatf("proc_pxl_o[%0d]", a), cap_mem[a], want);  // first only
      if (ok && col >= 16 && col < 144 && row >= 8 && row < 112) begin
        exp_bins[(col - 16) / 16]++;
        exp_tot++;
      end
    end
    for (i = 0; i < 8; i++) check($sformatf("histogram_o[%0d]", i), histogram[i], exp_bins[i]);
    check("colorpxls_o", colorpxls, exp_tot);
  endtask

  task automatic fill_random;
    int a;
    for (a = 0; a < color_proc_pkg::img_pxls; a++) src_mem[a] = color_proc_pkg::pxl_t'($urandom);
  endtask

  task automatic put_patch(input int col0, input int row0, input int w, input int h);
    int c, r;
    for (r = 0; r < h; r++)
      for (c = 0; c < w; c++) src_mem[(row0 + r) * 160 + col0 + c] = 12'hf00;  // pure red
  endtask

  // one press and release where the held level may step only once
  task automatic press_button;
    color_proc_pkg::rgb_filter_e old, want;
    int n;
    old  = rgbfilter;
    want = next_filter(old);
    @(posedge clk);
    proc_ctrl <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rgbfilter == old && n < 10);
    if (rgbfilter == old) begin
      $display("timeout: filter did not change within 10 cycles of a button press");
      err_cnt++;
    end
    check("rgbfilter_o after press", rgbfilter, want);
    repeat (8) @(negedge clk);
    check("rgbfilter_o while held", rgbfilter, want);
    @(posedge clk);
    proc_ctrl <= 1'b0;
    repeat (4) @(posedge clk);  // let the synchronizer see the release
  endtask

  task automatic set_filter(input color_proc_pkg::rgb_filter_e target);
    int n;
    n = 0;
    while (rgbfilter != target && n < 8) begin
      press_button;
      n++;
    end
    check("rgbfilter_o", rgbfilter, target);
  endtask

  task automatic report_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt == e0) $display("test %s: ok", name);
    else begin
      $display("test %s: failed with %0d errors", name, err_cnt - e0);
      fail_cnt++;
    end
  endtask

  task automatic reset_values;
    int e0, i;
    e0 = err_cnt;
    check("proc_we_o", proc_we, 0);
    check("new_frame_proc_o", frame_done, 0);
    check("orig_addr_o", orig_addr, 0);
    check("colorpxls_o", colorpxls, 0);
    for (i = 0; i < 8; i++) check($sformatf("histogram_o[%0d]", i), histogram[i], 0);
    check("rgbfilter_o", rgbfilter, color_proc_pkg::filt_none);
    report_test("after reset", e0);
  endtask

  task automatic none_filter_frame;
    int e0, i;
    e0 = err_cnt;
    fill_random;
    run_frame(0);
    verify_frame(color_proc_pkg::filt_none);
    for (i = 0; i < 8; i++) check($sformatf("histogram_o[%0d]", i), histogram[i], 1664);
    check("colorpxls_o", colorpxls, 13312);  // whole inner frame
    report_test("filt_none random image", e0);
  endtask

  task automatic filter_stepping;
    int e0, i;
    e0 = err_cnt;
    set_filter(color_proc_pkg::filt_none);
    for (i = 1; i <= 8; i++) begin
      press_button;
      check("rgbfilter_o step", rgbfilter, step_order[i % 8]);
    end
    report_test("filter stepping", e0);
  endtask

  task automatic color_filters;
    int e0, i;
    e0 = err_cnt;
    for (i = 1; i < 8; i++) begin  // red through white
      set_filter(step_order[i]);
      fill_random;
      run_frame(0);
      verify_frame(step_order[i]);
    end
    report_test("color filters random image", e0);
  endtask

  task automatic spatial_bins;
    int e0, a;
    e0 = err_cnt;
    set_filter(color_proc_pkg::filt_red);
    for (a = 0; a < color_proc_pkg::img_pxls; a++) src_mem[a] = 12'h000;
    put_patch(18, 20, 5, 4);     // 20 pixels in bin 0
    put_patch(64, 50, 16, 3);    // 48 pixels in bin 3
    put_patch(140, 100, 4, 12);  // 48 pixels in bin 7 down to the last inner row
    put_patch(0, 0, 10, 5);      // border patches are never counted
    put_patch(12, 40, 4, 4);
    put_patch(144, 60, 8, 4);
    put_patch(60, 112, 20, 3);
    run_frame(0);
    verify_frame(color_proc_pkg::filt_red);
    check("histogram_o[0]", histogram[0], 20);
    check("histogram_o[3]", histogram[3], 48);
    check("histogram_o[7]", histogram[7], 48);
    check("colorpxls_o", colorpxls, 116);
    check("border pixel written", cap_mem[0], 12'hf00);
    report_test("spatial bins", e0);
  endtask

  task automatic frame_restart;
    int e0;
    e0 = err_cnt;
    set_filter(color_proc_pkg::filt_red);
    fill_random;
    run_frame(300);
    verify_frame(color_proc_pkg::filt_red);
    repeat (200) @(posedge clk);
    check("new_frame_proc_o count after idle", done_cnt, 1);
    verify_frame(color_proc_pkg::filt_red);  // results still held
    fill_random;
    run_frame(0);
    verify_frame(color_proc_pkg::filt_red);
    report_test("frame restart", e0);
  endtask

  initial begin
    rst       = 1'b1;
    new_frame = 1'b0;
    proc_ctrl = 1'b0;
    orig_pxl  = '0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    void'($urandom(32675));
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    reset_values;
    none_filter_frame;
    filter_stepping;
    color_filters;
    spatial_bins;
    frame_restart;
    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) $display(">>> PASS");
    else $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== color_proc.sv ====
// top level of the color filter and spatial histogram unit, ties the four blocks together
`timescale 1ns/1ns

module color_proc (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       new_frame_i,   // frame buffer is full
  input  logic                                       proc_ctrl_i,   // filter step button
  input  color_proc_pkg::pxl_t                       orig_pxl_i,    // source mem read data
  output color_proc_pkg::pxl_addr_t                  orig_addr_o,
  output logic                                       proc_we_o,
  output color_proc_pkg::pxl_addr_t                  proc_addr_o,
  output color_proc_pkg::pxl_t                       proc_pxl_o,
  output logic                                       new_frame_proc_o,
  output color_proc_pkg::hist_bins_t                 histogram_o,
  output logic [color_proc_pkg::nb_inframe_pxls-1:0] colorpxls_o,
  output color_proc_pkg::rgb_filter_e                rgbfilter_o
);

  logic                      scan_valid;
  logic                      scan_last;
  logic                      scan_inframe;
  color_proc_pkg::pxl_addr_t scan_addr;
  color_proc_pkg::hist_bin_t scan_bin;
  logic                      class_pass;
  color_proc_pkg::pxl_t      class_pxl;

  frame_scanner i_frame_scanner (
    .clk            (clk),
    .rst            (rst),
    .new_frame_i    (new_frame_i),
    .orig_addr_o    (orig_addr_o),
    .scan_valid_o   (scan_valid),
    .scan_last_o    (scan_last),
    .scan_inframe_o (scan_inframe),
    .scan_addr_o    (scan_addr),
    .scan_bin_o     (scan_bin)
  );

  filter_select i_filter_select (
    .clk         (clk),
    .rst         (rst),
    .proc_ctrl_i (proc_ctrl_i),
    .filter_o    (rgbfilter_o)  // also feeds the classifier
  );

  color_classifier i_color_classifier (
    .clk          (clk),
    .rst          (rst),
    .scan_valid_i (scan_valid),
    .orig_pxl_i   (orig_pxl_i),
    .filter_i     (rgbfilter_o),
    .class_pass_o (class_pass),
    .class_pxl_o  (class_pxl)
  );

  color_histogram i_color_histogram (
    .clk              (clk),
    .rst              (rst),
    .scan_valid_i     (scan_valid),
    .scan_last_i      (scan_last),
    .scan_inframe_i   (scan_inframe),
    .scan_addr_i      (scan_addr),
    .scan_bin_i       (scan_bin),
    .class_pass_i     (class_pass),
    .class_pxl_i      (class_pxl),
    .proc_we_o        (proc_we_o),
    .proc_addr_o      (proc_addr_o),
    .proc_pxl_o       (proc_pxl_o),
    .histogram_o      (histogram_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o)
  );

endmodule

// ==== color_histogram.sv ====
// output side: writes the filtered image and builds the per-bin counts of passing pixels
`timescale 1ns/1ns

module color_histogram (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      scan_valid_i,
  input  logic                                      scan_last_i,
  input  logic                                      scan_inframe_i,
  input  color_proc_pkg::pxl_addr_t                 scan_addr_i,
  input  color_proc_pkg::hist_bin_t                 scan_bin_i,
  input  logic                                      class_pass_i,  // aligned one cycle later
  input  color_proc_pkg::pxl_t                      class_pxl_i,
  output logic                                      proc_we_o,     // write strobe, result mem
  output color_proc_pkg::pxl_addr_t                 proc_addr_o,
  output color_proc_pkg::pxl_t                      proc_pxl_o,
  output color_proc_pkg::hist_bins_t                histogram_o,   // held between frames
  output logic [color_proc_pkg::nb_inframe_pxls-1:0] colorpxls_o,  // sum over all bins
  output logic                                      new_frame_proc_o
);

  // scan tags delayed to meet the classifier register
  logic                      valid_d;
  logic                      last_d;
  logic                      inframe_d;
  color_proc_pkg::pxl_addr_t addr_d;
  color_proc_pkg::hist_bin_t bin_d;

  color_proc_pkg::hist_bins_t                acc_q, acc_nxt;  // running bin counts
  logic [color_proc_pkg::nb_inframe_pxls-1:0] tot_q, tot_nxt;  // running total
  color_proc_pkg::hist_val_t                 bin_inc;
  logic                                      count_en;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_d   <= 1'b0;
      last_d    <= 1'b0;
      inframe_d <= 1'b0;
      addr_d    <= '0;
      bin_d     <= '0;
    end else begin
      valid_d   <= scan_valid_i;
      last_d    <= scan_last_i;
      inframe_d <= scan_inframe_i;
      addr_d    <= scan_addr_i;
      bin_d     <= scan_bin_i;
    end
  end

  assign proc_we_o   = valid_d;
  assign proc_addr_o = addr_d;
  assign proc_pxl_o  = class_pass_i ? class_pxl_i : color_proc_pkg::black_pxl;

  // border pixels are written but never counted
  assign count_en = valid_d & inframe_d & class_pass_i;
  assign bin_inc  = acc_q[bin_d] + 1'b1;

  always_comb begin
    acc_nxt = acc_q;
    tot_nxt = tot_q;
    if (count_en) begin
      acc_nxt[bin_d] = bin_inc;
      tot_nxt        = tot_q + 1'b1;
    end
  end

  // the last pixel goes straight into the latched result
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q            <= '0;
      tot_q            <= '0;
      histogram_o      <= '0;
      colorpxls_o      <= '0;
      new_frame_proc_o <= 1'b0;
    end else begin
      new_frame_proc_o <= last_d;  // one cycle after the last write
      if (last_d) begin
        histogram_o <= acc_nxt;
        colorpxls_o <= tot_nxt;
        acc_q       <= '0;       // ready for the next frame
        tot_q       <= '0;
      end else begin
        acc_q <= acc_nxt;
        tot_q <= tot_nxt;
      end
    end
  end

endmodule

// ==== color_classifier.sv ====
// processing part: classifies each read pixel by color and registers the filter decision
`timescale 1ns/1ns

module color_classifier (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        scan_valid_i,  // orig_pxl_i holds a frame pixel
  input  color_proc_pkg::pxl_t        orig_pxl_i,
  input  color_proc_pkg::rgb_filter_e filter_i,
  output logic                        class_pass_o,  // pixel passes the filter, 1 cycle later
  output color_proc_pkg::pxl_t        class_pxl_o    // pixel delayed with the decision
);

  logic [color_proc_pkg::nb_chan-1:0] red, grn, blu;
  logic [color_proc_pkg::nb_chan-1:0] rg_dif, rb_dif, gb_dif;  // absolute differences
  logic rg_gt, rb_gt, gb_gt;     // pairwise ordering
  logic rg_sim, rb_sim, gb_sim;  // near each other
  logic rg_vd, rb_vd, gb_vd;     // far apart
  logic red_hit, grn_hit, blu_hit, yel_hit, mag_hit, cya_hit, gra_hit, whi_hit;
  logic pass_c;

  assign red = orig_pxl_i[color_proc_pkg::nb_pxl-1 -: color_proc_pkg::nb_chan];
  assign grn = orig_pxl_i[2*color_proc_pkg::nb_chan-1 -: color_proc_pkg::nb_chan];
  assign blu = orig_pxl_i[color_proc_pkg::nb_chan-1:0];

  assign rg_gt = red > grn;
  assign rb_gt = red > blu;
  assign gb_gt = grn > blu;

  assign rg_dif = rg_gt ? red - grn : grn - red;
  assign rb_dif = rb_gt ? red - blu : blu - red;
  assign gb_dif = gb_gt ? grn - blu : blu - grn;

  assign rg_sim = rg_dif <= color_proc_pkg::simil_limit;
  assign rb_sim = rb_dif <= color_proc_pkg::simil_limit;
  assign gb_sim = gb_dif <= color_proc_pkg::simil_limit;
  assign rg_vd  = rg_dif >= color_proc_pkg::vdif_limit;
  assign rb_vd  = rb_dif >= color_proc_pkg::vdif_limit;
  assign gb_vd  = gb_dif >= color_proc_pkg::vdif_limit;

  // ordering tree, the largest channel decides the branch
  always_comb begin
    {red_hit, grn_hit, blu_hit, yel_hit, mag_hit, cya_hit, gra_hit} = '0;
    if (rg_gt && rb_gt && gb_gt) begin         // r > g > b
      if (rg_vd)                red_hit = 1'b1;
      else if (rg_sim && rb_sim) gra_hit = 1'b1;
      else if (rg_sim && gb_vd)  yel_hit = 1'b1;  // r and g high, b low
    end else if (rg_gt && rb_gt) begin         // r > b >= g
      if (rb_vd)                red_hit = 1'b1;
      else if (rb_sim && rg_sim) gra_hit = 1'b1;
      else if (rb_sim && gb_vd)  mag_hit = 1'b1;
    end else if (rg_gt) begin                  // b >= r > g
      if (rb_vd)                blu_hit = 1'b1;
      else if (rb_sim && gb_sim) gra_hit = 1'b1;
      else if (rb_sim && rg_vd)  mag_hit = 1'b1;
    end else if (rb_gt) begin                  // g >= r > b
      if (rg_vd)                grn_hit = 1'b1;
      else if (rg_sim && rb_vd)  yel_hit = 1'b1;  // yellow checked before gray here
      else if (rg_sim && gb_sim) gra_hit = 1'b1;
    end else if (gb_gt) begin                  // g > b >= r
      if (gb_vd)                grn_hit = 1'b1;
      else if (gb_sim && rb_vd)  cya_hit = 1'b1;
      else if (gb_sim && rg_sim) gra_hit = 1'b1;
    end else begin                             // b >= g >= r
      if (gb_vd)                blu_hit = 1'b1;
      else if (gb_sim && rb_sim) gra_hit = 1'b1;
      else if (gb_sim && rg_vd)  cya_hit = 1'b1;
    end
  end

  // white is a gray with all channels at 12 or more
  assign whi_hit = gra_hit & (&{red[3:2], grn[3:2], blu[3:2]});

  always_comb begin
    case (filter_i)
      color_proc_pkg::filt_red:     pass_c = red_hit;
      color_proc_pkg::filt_green:   pass_c = grn_hit;
      color_proc_pkg::filt_blue:    pass_c = blu_hit;
      color_proc_pkg::filt_yellow:  pass_c = yel_hit;
      color_proc_pkg::filt_magenta: pass_c = mag_hit;
      color_proc_pkg::filt_cyan:    pass_c = cya_hit;
      color_proc_pkg::filt_white:   pass_c = whi_hit;
      default:                      pass_c = 1'b1;  // filt_none keeps everything
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) class_pass_o <= 1'b0;
    else     class_pass_o <= scan_valid_i & pass_c;  // low between frames
  end

  always_ff @(posedge clk) begin
    if (scan_valid_i) class_pxl_o <= orig_pxl_i;
  end

endmodule

// ==== filter_select.sv ====
// input side: steps the active color filter on each push of the process control button
`timescale 1ns/1ns

module filter_select (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        proc_ctrl_i,  // raw button level, async to clk
  output color_proc_pkg::rgb_filter_e filter_o      // filter now in use
);

  logic ctrl_meta_q;  // first sync stage
  logic ctrl_sync_q;  // safe to use
  logic ctrl_prev_q;  // last cycle's level for edge detect
  logic ctrl_rise;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_meta_q <= 1'b0;
      ctrl_sync_q <= 1'b0;
      ctrl_prev_q <= 1'b0;
    end else begin
      ctrl_meta_q <= proc_ctrl_i;
      ctrl_sync_q <= ctrl_meta_q;
      ctrl_prev_q <= ctrl_sync_q;
    end
  end

  // a held level gives a single step
  assign ctrl_rise = ctrl_sync_q & ~ctrl_prev_q;

  // none -> red -> green -> blue -> yellow -> magenta -> cyan -> white -> none
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filter_o <= color_proc_pkg::filt_none;
    end else if (ctrl_rise) begin
      case (filter_o)
        color_proc_pkg::filt_none:    filter_o <= color_proc_pkg::filt_red;
        color_proc_pkg::filt_red:     filter_o <= color_proc_pkg::filt_green;
        color_proc_pkg::filt_green:   filter_o <= color_proc_pkg::filt_blue;
        color_proc_pkg::filt_blue:    filter_o <= color_proc_pkg::filt_yellow;
        color_proc_pkg::filt_yellow:  filter_o <= color_proc_pkg::filt_magenta;
        color_proc_pkg::filt_magenta: filter_o <= color_proc_pkg::filt_cyan;
        color_proc_pkg::filt_cyan:    filter_o <= color_proc_pkg::filt_white;
        default:                      filter_o <= color_proc_pkg::filt_none;  // white wraps
      endcase
    end
  end

endmodule

// ==== frame_scanner.sv ====
// input side: walks the original image memory once per new_frame_i and tags each read pixel
`timescale 1ns/1ns

module frame_scanner (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      new_frame_i,     // one cycle start strobe
  output color_proc_pkg::pxl_addr_t orig_addr_o,     // read address to the source memory
  output logic                      scan_valid_o,    // orig_pxl_i valid this cycle
  output logic                      scan_last_o,     // last pixel of the frame
  output logic                      scan_inframe_o,  // pixel inside the counted area
  output color_proc_pkg::pxl_addr_t scan_addr_o,     // address of the pixel now on the bus
  output color_proc_pkg::hist_bin_t scan_bin_o       // histogram bin of that pixel
);

  logic                                scanning_q;
  color_proc_pkg::pxl_addr_t           addr_q;
  logic [color_proc_pkg::nb_cols-1:0]  col_q;
  logic [color_proc_pkg::nb_rows-1:0]  row_q;

  logic                      end_pxl;
  logic                      end_ln;
  logic                      inframe_c;
  color_proc_pkg::hist_bin_t bin_c;

  assign end_pxl = (addr_q == color_proc_pkg::img_pxls - 1);
  assign end_ln  = (col_q == color_proc_pkg::img_cols - 1);

  // address, column and row run together while scanning
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scanning_q <= 1'b0;
      addr_q     <= '0;
      col_q      <= '0;
      row_q      <= '0;
    end else if (scanning_q) begin
      if (end_pxl) begin  // frame done, park at zero
        scanning_q <= 1'b0;
        addr_q     <= '0;
        col_q      <= '0;
        row_q      <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
        if (end_ln) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end else if (new_frame_i) begin
      scanning_q <= 1'b1;  // strobes during a scan fall through here unseen
    end
  end

  assign orig_addr_o = addr_q;

  // inner frame is cols 16..143, rows 8..111
  assign inframe_c = scanning_q &&
                     (col_q >= color_proc_pkg::outframe_cols) &&
                     (col_q < color_proc_pkg::outframe_cols + color_proc_pkg::inframe_cols) &&
                     (row_q >= color_proc_pkg::outframe_rows) &&
                     (row_q < color_proc_pkg::outframe_rows + color_proc_pkg::inframe_rows);

  // inner column / 16, value is junk outside the inner frame but never used there
  assign bin_c = color_proc_pkg::hist_bin_t'((col_q - color_proc_pkg::outframe_cols) /
                 (color_proc_pkg::inframe_cols / color_proc_pkg::hist_bins));

  // one cycle delay to line up with the synchronous memory read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scan_valid_o   <= 1'b0;
      scan_last_o    <= 1'b0;
      scan_inframe_o <= 1'b0;
      scan_addr_o    <= '0;
      scan_bin_o     <= '0;
    end else begin
      scan_valid_o   <= scanning_q;
      scan_last_o    <= scanning_q & end_pxl;
      scan_inframe_o <= inframe_c;
      scan_addr_o    <= addr_q;
      scan_bin_o     <= bin_c;
    end
  end

endmodule

// ==== color_proc_pkg.sv ====
// shared geometry, color limits, widths and filter codes for the color filter and histogram unit
package color_proc_pkg;

  // frame geometry, qqvga 160x120
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;  // 19200 pixels per frame

  localparam int nb_img_pxls = 15;  // address width, 2^15 > 19200
  localparam int nb_cols     = 8;   // column counter 0..159
  localparam int nb_rows     = 7;   // row counter 0..119

  // border cut on each side before counting
  localparam int outframe_cols = 16;
  localparam int outframe_rows = 8;

  // inner frame left after taking the border away
  localparam int inframe_cols = img_cols - 2 * outframe_cols;  // 128
  localparam int inframe_rows = img_rows - 2 * outframe_rows;  // 104

  // spatial histogram, inner columns split in equal bins
  localparam int hist_bins       = 8;   // 16 columns per bin
  localparam int nb_hist_bins    = 3;
  localparam int nb_hist_val     = 11;  // up to 104 x 16 = 1664 per bin
  localparam int nb_inframe_pxls = 14;  // up to 128 x 104 = 13312 in total

  // pixel format rgb444
  localparam int nb_chan = 4;            // bits per channel
  localparam int nb_pxl  = 3 * nb_chan;  // red high, green middle, blue low

  // channel distance thresholds
  localparam int simil_limit = 2;  // |a-b| <= 2 means similar
  localparam int vdif_limit  = 7;  // |a-b| >= 7 means very different

  typedef logic [nb_pxl-1:0]      pxl_t;
  typedef logic [nb_img_pxls-1:0] pxl_addr_t;
  typedef logic [nb_hist_bins-1:0] hist_bin_t;
  typedef logic [nb_hist_val-1:0]  hist_val_t;

  // bin 0 is the leftmost
  typedef hist_val_t [hist_bins-1:0] hist_bins_t;

  localparam pxl_t black_pxl = '0;  // written for pixels that fail the filter

  // filter codes, one bit per primary that the filter keeps
  typedef enum logic [2:0] {
    filt_none    = 3'b000,  // every pixel passes
    filt_red     = 3'b100,
    filt_green   = 3'b010,
    filt_blue    = 3'b001,
    filt_yellow  = 3'b110,  // red and green
    filt_magenta = 3'b101,  // red and blue
    filt_cyan    = 3'b011,  // green and blue
    filt_white   = 3'b111   // bright gray
  } rgb_filter_e;

endpackage
